//--- src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// instruction side
`define CPU_WORD_W        16  // program and data word
`define CPU_ADDR_W        6   // program ram address
`define CPU_RAM_DEPTH     64
`define CPU_REG_COUNT     32
`define CPU_CONSOLE_ADDR  63  // reg2ram target that goes to tx

// serial side
`define TRACE_FIFO_DEPTH  8   // also the starting credit count
`define UART_CLK_PER_BIT  8   // short bit period for simulation

`endif

//--- src/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

  // high byte of the first instruction word
  typedef enum logic [7:0] {
    OP_JMP     = 8'd1,
    OP_RAM2REG = 8'd2,
    OP_REG2RAM = 8'd3,
    OP_NUM2REG = 8'd4
  } opcode_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_ANNOUNCE,     // send "S" once per run rise
    SEQ_FETCH_OP,
    SEQ_FETCH_ARG,
    SEQ_WAIT_CREDIT,  // hold until the fifo has room for the whole instruction
    SEQ_EXECUTE
  } seq_state_t;

endpackage

//--- src/uart_pkg.sv
`include "cpu_config.svh"

package uart_pkg;

  typedef logic [7:0] uart_byte_t;
  typedef logic [$clog2(`TRACE_FIFO_DEPTH+1)-1:0] credit_t;  // 0 .. fifo depth

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

//--- src/ram_if.sv
interface ram_if ();

  cpu_pkg::addr_t raddr;
  cpu_pkg::word_t rdata;  // valid one cycle after raddr
  logic           we;
  cpu_pkg::addr_t waddr;
  cpu_pkg::word_t wdata;

  modport sequencer (
    output raddr, we, waddr, wdata,
    input  rdata
  );

  modport memory (
    input  raddr, we, waddr, wdata,
    output rdata
  );

endinterface

//--- src/program_ram.sv
`include "cpu_config.svh"

module program_ram (
  input logic clk,
  ram_if.memory mem
);

  cpu_pkg::word_t words [`CPU_RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem.we) begin
      words[mem.waddr] <= mem.wdata;
    end
    mem.rdata <= words[mem.raddr];  // registered read every cycle
  end

endmodule

//--- src/cpu_sequencer.sv
`include "cpu_config.svh"

module cpu_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run,
  ram_if.sequencer             ram,
  output logic                 trace_push,
  output uart_pkg::uart_byte_t trace_byte,
  input  logic                 credit_return
);

  cpu_pkg::seq_state_t  state;
  cpu_pkg::addr_t       pc;
  cpu_pkg::word_t       op_word;
  cpu_pkg::word_t       arg_word;
  cpu_pkg::word_t       regs [`CPU_REG_COUNT];
  uart_pkg::credit_t    credits;
  logic                 run_q;
  logic                 rd_wait;    // second cycle of a fetch
  logic                 second;     // console byte still to push
  cpu_pkg::opcode_t     opcode;
  cpu_pkg::reg_idx_t    sel_reg;
  cpu_pkg::addr_t       target;
  logic                 to_console;
  uart_pkg::credit_t    need;
  uart_pkg::uart_byte_t op_char;
  logic                 push_now;
  uart_pkg::uart_byte_t push_char;

  assign opcode     = cpu_pkg::opcode_t'(op_word[`CPU_WORD_W-1 -: 8]);
  assign sel_reg    = op_word[$bits(cpu_pkg::reg_idx_t)-1:0];
  assign target     = arg_word[`CPU_ADDR_W-1:0];
  assign to_console = (opcode == cpu_pkg::OP_REG2RAM) &&
                      (target == cpu_pkg::addr_t'(`CPU_CONSOLE_ADDR));
  assign need       = to_console ? uart_pkg::credit_t'(2) : uart_pkg::credit_t'(1);

  // second fetch cycle keeps the same address so rdata lines up
  assign ram.raddr = (state == cpu_pkg::SEQ_FETCH_ARG) ? cpu_pkg::addr_t'(pc + 1'b1) : pc;
  assign ram.we    = (state == cpu_pkg::SEQ_EXECUTE) && !second &&
                     (opcode == cpu_pkg::OP_REG2RAM) && !to_console;
  assign ram.waddr = target;
  assign ram.wdata = regs[sel_reg];

  always_comb begin
    case (opcode)
      cpu_pkg::OP_JMP:     op_char = "1";
      cpu_pkg::OP_REG2RAM: op_char = "3";
      cpu_pkg::OP_NUM2REG: op_char = "4";
      default:             op_char = "X";  // ram2reg and unknown opcodes
    endcase
  end

  always_comb begin
    push_now  = 1'b0;
    push_char = op_char;
    case (state)
      cpu_pkg::SEQ_ANNOUNCE: begin
        push_now  = (credits != '0);
        push_char = "S";
      end
      cpu_pkg::SEQ_EXECUTE: begin
        push_now  = 1'b1;  // credits already checked in wait_credit
        push_char = second ? regs[sel_reg][7:0] : op_char;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= cpu_pkg::SEQ_IDLE;
      pc      <= '0;
      run_q   <= 1'b0;
      rd_wait <= 1'b0;
      second  <= 1'b0;
    end else begin
      run_q <= run;
      if (!run) begin
        state   <= cpu_pkg::SEQ_IDLE;
        rd_wait <= 1'b0;
        second  <= 1'b0;
      end else begin
        case (state)
          cpu_pkg::SEQ_IDLE: begin
            if (!run_q) state <= cpu_pkg::SEQ_ANNOUNCE;  // rising edge of run
          end
          cpu_pkg::SEQ_ANNOUNCE: begin
            if (credits != '0) begin
              pc    <= '0;
              state <= cpu_pkg::SEQ_FETCH_OP;
            end
          end
          cpu_pkg::SEQ_FETCH_OP: begin
            rd_wait <= !rd_wait;
            if (rd_wait) state <= cpu_pkg::SEQ_FETCH_ARG;
          end
          cpu_pkg::SEQ_FETCH_ARG: begin
            rd_wait <= !rd_wait;
            if (rd_wait) state <= cpu_pkg::SEQ_WAIT_CREDIT;
          end
          cpu_pkg::SEQ_WAIT_CREDIT: begin
            if (credits >= need) state <= cpu_pkg::SEQ_EXECUTE;
          end
          cpu_pkg::SEQ_EXECUTE: begin
            if (to_console && !second) begin
              second <= 1'b1;
            end else begin
              second <= 1'b0;
              pc     <= (opcode == cpu_pkg::OP_JMP) ? target : cpu_pkg::addr_t'(pc + 2'd2);
              state  <= cpu_pkg::SEQ_FETCH_OP;
            end
          end
          default: state <= cpu_pkg::SEQ_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_wait && state == cpu_pkg::SEQ_FETCH_OP) op_word <= ram.rdata;
    if (rd_wait && state == cpu_pkg::SEQ_FETCH_ARG) arg_word <= ram.rdata;
    trace_byte <= push_char;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (state == cpu_pkg::SEQ_EXECUTE && !second && opcode == cpu_pkg::OP_NUM2REG) begin
      regs[sel_reg] <= arg_word;
    end
  end

  // one credit out per push, one back per fifo pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits    <= uart_pkg::credit_t'(`TRACE_FIFO_DEPTH);
      trace_push <= 1'b0;
    end else begin
      credits    <= uart_pkg::credit_t'(credits + credit_return - push_now);
      trace_push <= push_now;
    end
  end

endmodule

//--- src/trace_fifo.sv
`include "cpu_config.svh"

module trace_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  uart_pkg::uart_byte_t push_byte,
  output logic                 tx_valid,
  output uart_pkg::uart_byte_t tx_byte,
  input  logic                 tx_ready,
  output logic                 credit_return
);

  localparam int PTR_W = $clog2(`TRACE_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`TRACE_FIFO_DEPTH - 1);

  uart_pkg::uart_byte_t slots [`TRACE_FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W:0]       count;
  logic                 pop;

  assign tx_valid = (count != '0);
  assign tx_byte  = slots[rd_ptr];
  assign pop      = tx_valid && tx_ready;

  always_ff @(posedge clk) begin
    if (push) slots[wr_ptr] <= push_byte;  // never full, the sender holds credits
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      count         <= count + push - pop;
      credit_return <= pop;  // one pulse per byte handed to the shifter
    end
  end

endmodule

//--- src/baud_timer.sv
`include "cpu_config.svh"

module baud_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic bit_start,
  output logic bit_done
);

  localparam int CNT_W = $clog2(`UART_CLK_PER_BIT);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`UART_CLK_PER_BIT - 1);

  logic [CNT_W-1:0] cnt;

  assign bit_done = (cnt == '0);  // last cycle of the bit period

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= RELOAD;
    end else if (bit_start || bit_done) begin
      cnt <= RELOAD;  // restart on a new frame, or roll into the next bit
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

//--- src/uart_shifter.sv
module uart_shifter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_valid,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                 tx_ready,
  output logic                 bit_start,
  input  logic                 bit_done,
  output logic                 tx
);

  uart_pkg::tx_state_t  state;
  uart_pkg::uart_byte_t shift_q;
  logic [2:0]           bit_cnt;

  assign tx_ready  = (state == uart_pkg::TX_IDLE);
  assign bit_start = tx_valid && tx_ready;  // byte accepted, frame begins

  always_comb begin
    case (state)
      uart_pkg::TX_START: tx = 1'b0;
      uart_pkg::TX_DATA:  tx = shift_q[0];  // lsb first
      default:            tx = 1'b1;        // idle and stop bit
    endcase
  end

  always_ff @(posedge clk) begin
    if (bit_start) begin
      shift_q <= tx_byte;
    end else if (state == uart_pkg::TX_DATA && bit_done) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::TX_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: if (bit_start) state <= uart_pkg::TX_START;
        uart_pkg::TX_START: begin
          if (bit_done) begin
            state   <= uart_pkg::TX_DATA;
            bit_cnt <= '0;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= uart_pkg::TX_STOP;
          end
        end
        uart_pkg::TX_STOP: if (bit_done) state <= uart_pkg::TX_IDLE;
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

//--- src/console_cpu_top.sv
module console_cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           run,
  input  logic           load_en,
  input  cpu_pkg::addr_t load_addr,
  input  cpu_pkg::word_t load_data,
  output logic           tx
);

  ram_if cpu_ram ();
  ram_if mem_ram ();

  logic                 trace_push;
  uart_pkg::uart_byte_t trace_byte;
  logic                 credit_return;
  logic                 tx_valid;
  uart_pkg::uart_byte_t tx_byte;
  logic                 tx_ready;
  logic                 bit_start;
  logic                 bit_done;

  // host load port owns the write side while the cpu is stopped
  assign mem_ram.raddr = cpu_ram.raddr;
  assign mem_ram.we    = run ? cpu_ram.we    : load_en;
  assign mem_ram.waddr = run ? cpu_ram.waddr : load_addr;
  assign mem_ram.wdata = run ? cpu_ram.wdata : load_data;
  assign cpu_ram.rdata = mem_ram.rdata;

  program_ram u_program_ram (
    .clk (clk),
    .mem (mem_ram.memory)
  );

  cpu_sequencer u_cpu_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .run           (run),
    .ram           (cpu_ram.sequencer),
    .trace_push    (trace_push),
    .trace_byte    (trace_byte),
    .credit_return (credit_return)
  );

  trace_fifo u_trace_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (trace_push),
    .push_byte     (trace_byte),
    .tx_valid      (tx_valid),
    .tx_byte       (tx_byte),
    .tx_ready      (tx_ready),
    .credit_return (credit_return)
  );

  uart_shifter u_uart_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_valid  (tx_valid),
    .tx_byte   (tx_byte),
    .tx_ready  (tx_ready),
    .bit_start (bit_start),
    .bit_done  (bit_done),
    .tx        (tx)
  );

  baud_timer u_baud_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .bit_start (bit_start),
    .bit_done  (bit_done)
  );

endmodule

//--- test/tb_console_cpu.sv
`include "cpu_config.svh"

module tb_console_cpu;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 5;
  localparam int MEM_WORDS   = 512;

  logic           clk;
  logic           rst_n;
  logic           run;
  logic           load_en;
  cpu_pkg::addr_t load_addr;
  cpu_pkg::word_t load_data;
  logic           tx;

  logic [15:0] case_mem [MEM_WORDS];  // flat image of the cases file
  int          byte_errors;
  int          stop_errors;
  int          other_errors;
  time         watchdog_limit = 0;

  console_cpu_top u_console_cpu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .tx        (tx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_byte(input int index, input uart_pkg::uart_byte_t expected,
                            input uart_pkg::uart_byte_t actual);
    if (actual !== expected) begin
      byte_errors++;
      $display("FAILED tx byte %0d: expected %h, got %h", index, expected, actual);
    end
  endtask

  task automatic check_stop_bit(input int index, input logic actual);
    if (actual !== 1'b1) begin
      stop_errors++;
      $display("FAILED tx stop bit of byte %0d: expected 1, got %h", index, actual);
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d byte, %0d stop bit, %0d other",
             byte_errors, stop_errors, other_errors);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #DRIVE_DELAY;
    run     = 1'b0;
    load_en = 1'b0;
    rst_n   = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
  endtask

  task automatic load_program(input int base, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      load_en   = 1'b1;
      load_addr = cpu_pkg::addr_t'(i);
      load_data = cpu_pkg::word_t'(case_mem[base + i]);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    load_en = 1'b0;
  endtask

  // sampled on falling edges, half a clock away from any tx change
  task automatic receive_byte(output uart_pkg::uart_byte_t data, output logic stop_bit);
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);  // start bit edge
    repeat (`UART_CLK_PER_BIT / 2) @(negedge clk);
    if (tx !== 1'b0) begin
      other_errors++;
      $display("start bit on tx did not stay low to its middle");
    end
    for (int b = 0; b < 8; b++) begin
      repeat (`UART_CLK_PER_BIT) @(negedge clk);
      data[b] = tx;  // lsb first
    end
    repeat (`UART_CLK_PER_BIT) @(negedge clk);
    stop_bit = tx;
  endtask

  task automatic run_case(input int case_num, inout int pos);
    int                   word_count;
    int                   byte_count;
    int                   prog_base;
    int                   exp_base;
    uart_pkg::uart_byte_t got;
    logic                 stop_bit;
    word_count = int'(case_mem[pos]);
    prog_base  = pos + 1;
    byte_count = int'(case_mem[prog_base + word_count]);
    exp_base   = prog_base + word_count + 1;
    $display("case %0d: %0d words, %0d bytes", case_num, word_count, byte_count);
    reset_dut();
    if (tx !== 1'b1) begin
      other_errors++;
      $display("tx line is not idle high after reset");
    end
    load_program(prog_base, word_count);
    @(posedge clk);
    #DRIVE_DELAY;
    run = 1'b1;
    for (int i = 0; i < byte_count; i++) begin
      receive_byte(got, stop_bit);
      check_byte(i, uart_pkg::uart_byte_t'(case_mem[exp_base + i]), got);
      check_stop_bit(i, stop_bit);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    run = 1'b0;
    pos = exp_base + byte_count;
  endtask

  initial begin
    int case_count;
    int total_bytes;
    int scan;
    int pos;
    rst_n        = 1'b0;
    run          = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    byte_errors  = 0;
    stop_errors  = 0;
    other_errors = 0;
    $readmemh("test/console_cases.txt", case_mem);
    case_count  = int'(case_mem[0]);
    total_bytes = 0;
    scan        = 1;
    for (int c = 0; c < case_count; c++) begin
      scan = scan + 1 + int'(case_mem[scan]);  // skip the program words
      total_bytes += int'(case_mem[scan]);
      scan = scan + 1 + int'(case_mem[scan]);
    end
    // four times the serial time, plus reset and load per case
    watchdog_limit = time'(total_bytes) * 10 * `UART_CLK_PER_BIT * CLK_PERIOD * 4 +
                     time'(case_count) * 200 * CLK_PERIOD + 100 * CLK_PERIOD;
    if (case_count == 0) begin
      other_errors++;
      $display("no cases were read from test/console_cases.txt");
    end
    pos = 1;
    for (int c = 0; c < case_count; c++) begin
      run_case(c + 1, pos);
    end
    print_counts();
    if (byte_errors + stop_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_limit != 0);
    #(watchdog_limit);
    other_errors++;
    $display("timeout: tx did not deliver all expected bytes in time");
    print_counts();
    $display("Test failed");
    $finish;
  end

endmodule

//--- test/console_cases.txt
// console cpu cases for $readmemh, every value hex
// first the case count, then per case: word count, program words, byte count, tx bytes
0005

// num2reg r1 then console store of r1, ends in a self jump
0006
0401 0041 0301 003F 0100 0004
0006
0053 0034 0033 0041 0031 0031

// store r2 to ram 0x20, then console store of r2 shows it unchanged
0008
0402 0042 0302 0020 0302 003F 0100 0006
0007
0053 0034 0033 0033 0042 0031 0031

// jmp back to 0 repeats the trace
0006
0405 0037 0305 003F 0100 0000
000D
0053 0034 0033 0037 0031 0034 0033 0037 0031 0034 0033 0037 0031

// ram2reg and other unknown opcodes
000A
0201 0005 0000 0000 0700 0000 FF1F 003F 0100 0008
0007
0053 0058 0058 0058 0058 0031 0031

// loop of six console stores, run twice, fills the fifo
0012
0401 0061 0402 0062 0301 003F 0302 003F 0301 003F 0302 003F 0301 003F 0302 003F
0100 0004
001D
0053 0034 0034 0033 0061 0033 0062 0033 0061 0033 0062 0033 0061 0033 0062 0031
0033 0061 0033 0062 0033 0061 0033 0062 0033 0061 0033 0062 0031

//--- filelist.f
+incdir+src
src/cpu_pkg.sv
src/uart_pkg.sv
src/ram_if.sv
src/program_ram.sv
src/cpu_sequencer.sv
src/trace_fifo.sv
src/baud_timer.sv
src/uart_shifter.sv
src/console_cpu_top.sv
test/tb_console_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_console_cpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
